// ==== rtl/ecc_code_pkg.sv ====
package ecc_code_pkg;

  localparam int unsigned CHUNK_SIZE = hci_size_pkg::BW;
  localparam int unsigned RSMETAW = 1;  // response carries r_opc only

  // hsiao check widths, log2(k)+2 each
  localparam int unsigned EW_DW = $clog2(CHUNK_SIZE) + 2;
  localparam int unsigned EW_RQMETA = $clog2(hci_size_pkg::RQMETAW) + 2;
  localparam int unsigned EW_RSMETA = $clog2(RSMETAW) + 2;

  localparam int unsigned EW = hci_size_pkg::N_CHUNK * EW_DW + EW_RQMETA;
  localparam int unsigned REW = hci_size_pkg::N_CHUNK * EW_DW + EW_RSMETA;

  // stored chunk is {check, byte}
  localparam int unsigned CHUNK_CW = CHUNK_SIZE + EW_DW;
  localparam int unsigned CW_W = hci_size_pkg::N_CHUNK * CHUNK_CW;

  localparam int unsigned MAX_EW = 8;  // widest check vector a column can have

  typedef logic [EW-1:0]     req_ecc_t;
  typedef logic [REW-1:0]    rsp_ecc_t;
  typedef logic [CW_W-1:0]   codeword_t;
  typedef logic [MAX_EW-1:0] col_t;

  // bit 0 single error fixed, bit 1 uncorrectable
  typedef logic [1:0] ecc_err_t;

  // column idx of the parity-check matrix for a given check width.
  // odd weights of three or more come first, even weights only when those
  // run out (the two-bit opcode code has no odd column left)
  function automatic col_t hsiao_column(input int unsigned idx, input int unsigned width);
    col_t col;
    int unsigned cnt;
    int unsigned ones;
    col = '0;
    cnt = 0;
    for (int pass = 0; pass < 2; pass++) begin
      for (int unsigned v = 1; v < (1 << width); v++) begin
        ones = $countones(col_t'(v));
        if ((pass == 0 && ones >= 3 && ones[0]) ||
            (pass == 1 && ones >= 2 && !ones[0])) begin
          if (cnt == idx) begin
            col = col_t'(v);
          end
          cnt++;
        end
      end
    end
    return col;
  endfunction

endpackage

// ==== rtl/ecc_mem_array.sv ====
`timescale 1ns/1ps

module ecc_mem_array (
  input  logic                    clk,
  input  logic                    req,
  input  logic                    we,
  input  hci_size_pkg::addr_t     addr,
  input  hci_size_pkg::be_t       be,
  input  ecc_code_pkg::codeword_t wdata,
  output ecc_code_pkg::codeword_t rdata
);
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  codeword_t mem [2**AW];

  always_ff @(posedge clk) begin
    if (req) begin
      if (we) begin
        // byte plus its check bits move as one chunk
        for (int c = 0; c < N_CHUNK; c++) begin
          if (be[c]) begin
            mem[addr][c*CHUNK_CW +: CHUNK_CW] <= wdata[c*CHUNK_CW +: CHUNK_CW];
          end
        end
      end else begin
        rdata <= mem[addr];  // held until the next read
      end
    end
  end

endmodule

// ==== rtl/ecc_tcdm_top.sv ====
`timescale 1ns/1ps

module ecc_tcdm_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  output logic                    gnt,
  input  hci_size_pkg::addr_t     add,
  input  logic                    wen,
  input  hci_size_pkg::data_t     data,
  input  hci_size_pkg::be_t       be,
  input  ecc_code_pkg::codeword_t inj_mask,
  output hci_size_pkg::data_t     r_data,
  output logic                    r_opc,
  output ecc_code_pkg::ecc_err_t  r_err,
  output logic                    r_valid,
  input  logic                    r_ready
);
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  logic      mem_req;
  logic      mem_we;
  addr_t     mem_addr;
  be_t       mem_be;
  codeword_t mem_wdata;
  codeword_t mem_rdata;

  hci_core_intf host_bus ();
  hci_core_intf mem_bus ();

  // host ports onto the unprotected bus
  assign host_bus.req     = req;
  assign host_bus.add     = add;
  assign host_bus.wen     = wen;
  assign host_bus.data    = data;
  assign host_bus.be      = be;
  assign host_bus.ecc     = '0;  // check bits are added by the bridge
  assign host_bus.r_ready = r_ready;
  assign gnt     = host_bus.gnt;
  assign r_data  = host_bus.r_data;
  assign r_opc   = host_bus.r_opc;
  assign r_valid = host_bus.r_valid;

  tcdm_ecc_bridge i_bridge (
    .tcdm_target    ( host_bus ),
    .tcdm_initiator ( mem_bus  ),
    .r_err          ( r_err    )
  );

  tcdm_bank_ctrl i_ctrl (
    .clk         ( clk       ),
    .rst         ( rst       ),
    .tcdm_target ( mem_bus   ),
    .inj_mask    ( inj_mask  ),
    .mem_req     ( mem_req   ),
    .mem_we      ( mem_we    ),
    .mem_addr    ( mem_addr  ),
    .mem_be      ( mem_be    ),
    .mem_wdata   ( mem_wdata ),
    .mem_rdata   ( mem_rdata )
  );

  ecc_mem_array i_array (
    .clk   ( clk       ),
    .req   ( mem_req   ),
    .we    ( mem_we    ),
    .addr  ( mem_addr  ),
    .be    ( mem_be    ),
    .wdata ( mem_wdata ),
    .rdata ( mem_rdata )
  );

endmodule

// ==== rtl/hci_core_intf.sv ====
`timescale 1ns/1ps

interface hci_core_intf;
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  // request channel
  logic     req;
  logic     gnt;
  addr_t    add;
  logic     wen;  // high for read
  data_t    data;
  be_t      be;
  req_ecc_t ecc;  // {byte checks, metadata checks}

  // response channel
  data_t    r_data;
  rsp_ecc_t r_ecc;  // {byte checks, opcode checks}
  logic     r_opc;
  logic     r_valid;
  logic     r_ready;

  modport initiator (
    output req, add, wen, data, be, ecc, r_ready,
    input  gnt, r_data, r_ecc, r_opc, r_valid
  );

  modport target (
    input  req, add, wen, data, be, ecc, r_ready,
    output gnt, r_data, r_ecc, r_opc, r_valid
  );

  modport monitor (
    input req, gnt, add, wen, data, be, ecc,
    input r_data, r_ecc, r_opc, r_valid, r_ready
  );

endinterface

// ==== rtl/hci_size_pkg.sv ====
package hci_size_pkg;

  // port geometry of the single TCDM bank
  localparam int unsigned AW = 8;  // word address
  localparam int unsigned DW = 32;
  localparam int unsigned BW = 8;
  localparam int unsigned N_CHUNK = DW / BW;

  // request metadata is {add, wen, be}
  localparam int unsigned RQMETAW = AW + 1 + N_CHUNK;

  typedef logic [AW-1:0]      addr_t;
  typedef logic [DW-1:0]      data_t;
  typedef logic [N_CHUNK-1:0] be_t;  // one bit per byte chunk
  typedef logic [RQMETAW-1:0] rqmeta_t;

endpackage

// ==== rtl/hsiao_ecc_dec.sv ====
`timescale 1ns/1ps

module hsiao_ecc_dec #(
  parameter int unsigned DataWidth = 8,
  parameter int unsigned ProtWidth = 5
) (
  input  logic [DataWidth+ProtWidth-1:0] in,  // {check, data}
  output logic [DataWidth-1:0]           out,
  output logic [ProtWidth-1:0]           syndrome,
  output ecc_code_pkg::ecc_err_t         err
);
  import ecc_code_pkg::*;

  logic [DataWidth-1:0] data_in;
  logic [ProtWidth-1:0] chk_in;
  logic                 hit;  // syndrome names a data bit

  assign {chk_in, data_in} = in;

  always_comb begin : calc_syn
    col_t col;
    syndrome = chk_in;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      col = hsiao_column(i, ProtWidth);
      syndrome ^= col[ProtWidth-1:0] & {ProtWidth{data_in[i]}};
    end
  end

  // flip the one data bit whose column equals the syndrome
  always_comb begin : fix_data
    col_t col;
    out = data_in;
    hit = 1'b0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      col = hsiao_column(i, ProtWidth);
      if (syndrome == col[ProtWidth-1:0]) begin
        out[i] = ~data_in[i];
        hit = 1'b1;
      end
    end
  end

  always_comb begin
    if (syndrome == '0) begin
      err = 2'b00;
    end else if (hit || $countones(syndrome) == 1) begin
      err = 2'b01;  // data bit or a lone check bit
    end else begin
      err = 2'b10;
    end
  end

endmodule

// ==== rtl/hsiao_ecc_enc.sv ====
`timescale 1ns/1ps

module hsiao_ecc_enc #(
  parameter int unsigned DataWidth = 8,
  parameter int unsigned ProtWidth = 5
) (
  input  logic [DataWidth-1:0]           in,
  output logic [DataWidth+ProtWidth-1:0] out  // {check, data}
);
  import ecc_code_pkg::*;

  logic [ProtWidth-1:0] chk;

  // each data bit toggles the check rows where its column is set
  always_comb begin : calc_chk
    col_t col;
    chk = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      col = hsiao_column(i, ProtWidth);
      chk ^= col[ProtWidth-1:0] & {ProtWidth{in[i]}};
    end
  end

  assign out = {chk, in};

endmodule

// ==== rtl/tcdm_bank_ctrl.sv ====
`timescale 1ns/1ps

module tcdm_bank_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  hci_core_intf.target            tcdm_target,
  input  ecc_code_pkg::codeword_t inj_mask,
  output logic                    mem_req,
  output logic                    mem_we,
  output hci_size_pkg::addr_t     mem_addr,
  output hci_size_pkg::be_t       mem_be,
  output ecc_code_pkg::codeword_t mem_wdata,
  input  ecc_code_pkg::codeword_t mem_rdata
);
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  typedef enum logic {
    IDLE,
    RESP
  } bank_state_e;

  bank_state_e state_q;
  bank_state_e state_d;

  rqmeta_t  meta_fix;
  ecc_err_t meta_err;
  addr_t    add_fix;
  logic     wen_fix;
  be_t      be_fix;
  logic     hs;
  logic     access;
  logic     rd_q;  // response carries read data
  logic     opc_q;

  codeword_t                          wr_cw;
  logic [N_CHUNK-1:0][CHUNK_SIZE-1:0] rd_data;
  logic [N_CHUNK-1:0][EW_DW-1:0]      rd_ecc;
  logic [N_CHUNK-1:0][EW_DW-1:0]      rsp_data_ecc;
  logic [EW_RSMETA:0]                 opc_enc;  // {check, opc}

  hsiao_ecc_dec #(
    .DataWidth ( RQMETAW   ),
    .ProtWidth ( EW_RQMETA )
  ) i_meta_dec (
    .in       ( {tcdm_target.ecc[EW_RQMETA-1:0], tcdm_target.add, tcdm_target.wen,
                 tcdm_target.be} ),
    .out      ( meta_fix ),
    .syndrome (  ),
    .err      ( meta_err )
  );

  assign {add_fix, wen_fix, be_fix} = meta_fix;

  assign tcdm_target.gnt = (state_q == IDLE);
  assign hs     = tcdm_target.req & tcdm_target.gnt;
  assign access = hs & ~meta_err[1];  // bad metadata never reaches the array

  for (genvar c = 0; c < N_CHUNK; c++) begin : gen_chunk
    assign wr_cw[c*CHUNK_CW +: CHUNK_CW] = {tcdm_target.ecc[EW_RQMETA + c*EW_DW +: EW_DW],
                                            tcdm_target.data[c*CHUNK_SIZE +: CHUNK_SIZE]};
    assign {rd_ecc[c], rd_data[c]} = mem_rdata[c*CHUNK_CW +: CHUNK_CW];
  end

  assign mem_req   = access;
  assign mem_we    = ~wen_fix;
  assign mem_addr  = add_fix;
  assign mem_be    = be_fix;
  assign mem_wdata = wr_cw ^ inj_mask;  // deliberate bit flips for test

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (hs) state_d = RESP;
      RESP: if (tcdm_target.r_ready) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      rd_q    <= 1'b0;
      opc_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (hs) begin
        rd_q  <= access & wen_fix;
        opc_q <= meta_err[1];
      end
    end
  end

  hsiao_ecc_enc #(
    .DataWidth ( RSMETAW   ),
    .ProtWidth ( EW_RSMETA )
  ) i_opc_enc (
    .in  ( opc_q ),
    .out ( opc_enc )
  );

  // write responses go out as all-zero codewords, which decode clean
  assign rsp_data_ecc = rd_q ? rd_ecc : '0;

  assign tcdm_target.r_valid = (state_q == RESP);
  assign tcdm_target.r_opc   = opc_enc[0];
  assign tcdm_target.r_data  = rd_q ? rd_data : '0;
  assign tcdm_target.r_ecc   = {rsp_data_ecc, opc_enc[EW_RSMETA:1]};

endmodule

// ==== rtl/tcdm_ecc_bridge.sv ====
`timescale 1ns/1ps

module tcdm_ecc_bridge (
  hci_core_intf.target           tcdm_target,
  hci_core_intf.initiator        tcdm_initiator,
  output ecc_code_pkg::ecc_err_t r_err
);
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  logic [N_CHUNK-1:0][CHUNK_SIZE-1:0] data_enc;
  logic [N_CHUNK-1:0][EW_DW-1:0]      data_ecc;
  rqmeta_t                            meta_enc;
  logic [EW_RQMETA-1:0]               meta_ecc;

  logic [N_CHUNK-1:0][EW_DW-1:0]      r_data_ecc;
  logic [N_CHUNK-1:0][CHUNK_SIZE-1:0] r_data_dec;
  ecc_err_t [N_CHUNK-1:0]             r_data_err;
  ecc_err_t                           r_meta_err;
  logic                               any_cor;
  logic                               any_unc;

  // request side, one encoder per byte
  for (genvar ii = 0; ii < N_CHUNK; ii++) begin : gen_data_enc
    hsiao_ecc_enc #(
      .DataWidth ( CHUNK_SIZE ),
      .ProtWidth ( EW_DW      )
    ) i_data_enc (
      .in  ( tcdm_target.data[ii*CHUNK_SIZE +: CHUNK_SIZE] ),
      .out ( {data_ecc[ii], data_enc[ii]} )
    );
  end

  hsiao_ecc_enc #(
    .DataWidth ( RQMETAW   ),
    .ProtWidth ( EW_RQMETA )
  ) i_meta_enc (
    .in  ( {tcdm_target.add, tcdm_target.wen, tcdm_target.be} ),
    .out ( {meta_ecc, meta_enc} )
  );

  assign tcdm_initiator.req  = tcdm_target.req;
  assign tcdm_target.gnt     = tcdm_initiator.gnt;
  assign tcdm_initiator.data = data_enc;  // unchanged payload
  assign {tcdm_initiator.add, tcdm_initiator.wen, tcdm_initiator.be} = meta_enc;
  assign tcdm_initiator.ecc  = {data_ecc, meta_ecc};
  assign tcdm_initiator.r_ready = tcdm_target.r_ready;

  // response side
  assign r_data_ecc = tcdm_initiator.r_ecc[REW-1:EW_RSMETA];

  for (genvar ii = 0; ii < N_CHUNK; ii++) begin : gen_data_dec
    hsiao_ecc_dec #(
      .DataWidth ( CHUNK_SIZE ),
      .ProtWidth ( EW_DW      )
    ) i_data_dec (
      .in       ( {r_data_ecc[ii], tcdm_initiator.r_data[ii*CHUNK_SIZE +: CHUNK_SIZE]} ),
      .out      ( r_data_dec[ii] ),
      .syndrome (  ),
      .err      ( r_data_err[ii] )
    );
  end

  hsiao_ecc_dec #(
    .DataWidth ( RSMETAW   ),
    .ProtWidth ( EW_RSMETA )
  ) i_opc_dec (
    .in       ( {tcdm_initiator.r_ecc[EW_RSMETA-1:0], tcdm_initiator.r_opc} ),
    .out      ( tcdm_target.r_opc ),
    .syndrome (  ),
    .err      ( r_meta_err )
  );

  assign tcdm_target.r_data  = r_data_dec;
  assign tcdm_target.r_ecc   = '0;  // host side sees corrected values only
  assign tcdm_target.r_valid = tcdm_initiator.r_valid;

  always_comb begin
    any_cor = r_meta_err[0];
    any_unc = r_meta_err[1];
    for (int c = 0; c < N_CHUNK; c++) begin
      any_cor |= r_data_err[c][0];
      any_unc |= r_data_err[c][1];
    end
  end

  assign r_err = {any_unc, any_cor};  // or of all five decoder statuses

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ECC TCDM testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_ecc_tcdm -Mdir obj_dir -o tb_ecc_tcdm
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_ecc_tcdm +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF ">>> PASS" "$LOG"; then
  exit 0
fi
exit 1

// ==== sim/tb_ecc_tcdm.sv ====
`timescale 1ns/1ps

module tb_ecc_tcdm;
  import hci_size_pkg::*;
  import ecc_code_pkg::*;

  localparam int TIMEOUT = 50;  // cycles allowed per wait

  logic      clk, rst, req, gnt, wen, r_opc, r_valid, r_ready;
  addr_t     add;
  data_t     data, r_data;
  be_t       be;
  codeword_t inj_mask;
  ecc_err_t  r_err;

  data_t       model_data [2**AW];  // intended contents
  codeword_t   model_cw [2**AW];    // what the array should hold, flips included
  addr_t       used_q [$];
  logic [31:0] lfsr = 32'd91411;
  int          n_checks, n_errors, chk0, err0;

  ecc_tcdm_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic addr_t pick_addr();
    return used_q[rand_bits(8) % used_q.size()];
  endfunction

  // clean stored word, each chunk is {check bits, byte}
  function automatic codeword_t ref_codeword(input data_t d);
    codeword_t        cw;
    col_t             col;
    logic [EW_DW-1:0] chk;
    for (int c = 0; c < N_CHUNK; c++) begin
      chk = '0;
      for (int i = 0; i < CHUNK_SIZE; i++) begin
        col = hsiao_column(i, EW_DW);
        if (d[c*CHUNK_SIZE + i]) chk ^= col[EW_DW-1:0];
      end
      cw[c*CHUNK_CW +: CHUNK_CW] = {chk, d[c*CHUNK_SIZE +: CHUNK_SIZE]};
    end
    return cw;
  endfunction

  // one or two flips inside a single random chunk
  function automatic codeword_t flip_mask(input int nflip);
    codeword_t m;
    int        c;
    int        p;
    m = '0;
    c = int'(rand_bits(2));
    p = int'(rand_bits(4) % CHUNK_CW);
    m[c*CHUNK_CW + p] = 1'b1;
    if (nflip == 2) begin
      p = (p + 1 + int'(rand_bits(4) % (CHUNK_CW - 1))) % CHUNK_CW;
      m[c*CHUNK_CW + p] = 1'b1;
    end
    return m;
  endfunction

  function automatic ecc_err_t exp_err(input addr_t a);
    codeword_t diff;
    ecc_err_t  e;
    int        nflip;
    diff = model_cw[a] ^ ref_codeword(model_data[a]);
    e = 2'b00;
    for (int c = 0; c < N_CHUNK; c++) begin
      nflip = $countones(diff[c*CHUNK_CW +: CHUNK_CW]);
      if (nflip >= 2) begin
        e[1] = 1'b1;  // this chunk cannot be fixed
      end else if (nflip == 1) begin
        e[0] = 1'b1;
      end
    end
    return e;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input ecc_err_t got, input ecc_err_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_opc(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic give_up(input string what);
    $display("timed out waiting for %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  // one request and its response, r_ready held low for stall cycles
  task automatic run_txn(input addr_t a, input logic rd, input data_t d, input be_t b,
                         input codeword_t m, input int stall, output data_t got_data,
                         output ecc_err_t got_err, output logic got_opc);
    int cnt;
    @(posedge clk);
    req      <= 1'b1;
    add      <= a;
    wen      <= rd;
    data     <= d;
    be       <= b;
    inj_mask <= m;
    r_ready  <= (stall == 0);
    cnt = 0;
    @(negedge clk);
    while (!gnt) begin
      cnt++;
      if (cnt > TIMEOUT) give_up("gnt");
      @(negedge clk);
    end
    @(posedge clk);  // handshake
    req      <= 1'b0;
    inj_mask <= '0;
    cnt = 0;
    @(negedge clk);
    while (!r_valid) begin
      cnt++;
      if (cnt > TIMEOUT) give_up("r_valid");
      @(negedge clk);
    end
    n_checks++;
    if (cnt != 0) begin
      n_errors++;
      $display("error at %0t: r_valid came %0d cycles late", $time, cnt);
    end
    got_data = r_data;
    got_err  = r_err;
    got_opc  = r_opc;
    check_opc(gnt, 1'b0, "gnt with response pending");
    for (int s = stall; s > 0; s--) begin
      @(posedge clk);
      if (s == 1) r_ready <= 1'b1;
      @(negedge clk);
      check_opc(r_valid, 1'b1, "r_valid while stalled");
      check_opc(gnt, 1'b0, "gnt while stalled");
      check_data(r_data, got_data, "held r_data");
      check_err(r_err, got_err, "held r_err");
      check_opc(r_opc, got_opc, "held r_opc");
    end
    @(posedge clk);  // response taken here
    @(negedge clk);
    check_opc(gnt, 1'b1, "gnt after response");
    check_opc(r_valid, 1'b0, "r_valid after response");
  endtask

  task automatic write_word(input addr_t a, input data_t d, input be_t b, input codeword_t m);
    data_t     rdat;
    ecc_err_t  rerr;
    logic      ropc;
    codeword_t cw;
    run_txn(a, 1'b0, d, b, m, 0, rdat, rerr, ropc);
    check_data(rdat, '0, "write r_data");
    check_err(rerr, 2'b00, "write r_err");
    check_opc(ropc, 1'b0, "write r_opc");
    cw = ref_codeword(d) ^ m;
    for (int c = 0; c < N_CHUNK; c++) begin
      if (b[c]) begin
        model_data[a][c*CHUNK_SIZE +: CHUNK_SIZE] = d[c*CHUNK_SIZE +: CHUNK_SIZE];
        model_cw[a][c*CHUNK_CW +: CHUNK_CW] = cw[c*CHUNK_CW +: CHUNK_CW];
      end
    end
  endtask

  task automatic read_word(input addr_t a, input int stall);
    data_t    rdat;
    ecc_err_t rerr;
    ecc_err_t eerr;
    logic     ropc;
    eerr = exp_err(a);
    run_txn(a, 1'b1, '0, '1, '0, stall, rdat, rerr, ropc);
    if (!eerr[1]) check_data(rdat, model_data[a], "read r_data");
    check_err(rerr, eerr, "read r_err");
    check_opc(ropc, 1'b0, "read r_opc");
  endtask

  task automatic end_test(input string name);
    $display("test %-26s %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
    chk0 = n_checks;
    err0 = n_errors;
  endtask

  initial begin
    addr_t a;
    rst      = 1'b1;
    req      = 1'b0;
    add      = '0;
    wen      = 1'b0;
    data     = '0;
    be       = '0;
    inj_mask = '0;
    r_ready  = 1'b0;
    n_checks = 0;
    n_errors = 0;
    chk0     = 0;
    err0     = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 16; i++) begin
      a = addr_t'(rand_bits(AW));
      write_word(a, rand_bits(DW), '1, '0);
      used_q.push_back(a);
    end
    foreach (used_q[i]) read_word(used_q[i], 0);
    end_test("full writes and reads");

    for (int i = 0; i < 16; i++) begin
      a = pick_addr();
      write_word(a, rand_bits(DW), be_t'(rand_bits(N_CHUNK)), '0);
      read_word(a, 0);
    end
    end_test("partial writes");

    for (int i = 0; i < 12; i++) begin
      a = pick_addr();
      write_word(a, rand_bits(DW), '1, flip_mask(1));
      read_word(a, 0);
    end
    end_test("single bit flips");

    for (int i = 0; i < 12; i++) begin
      a = pick_addr();
      write_word(a, rand_bits(DW), '1, flip_mask(2));
      read_word(a, 0);
    end
    end_test("double bit flips");

    for (int i = 0; i < 12; i++) begin
      read_word(pick_addr(), int'(rand_bits(3)));  // up to 7 stalled cycles
    end
    end_test("back-pressure reads");

    n_errors += i_dut.i_assert.n_fail;  // protocol assertion failures
    $display("done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/tb_ecc_tcdm_assert.sv ====
`timescale 1ns/1ps

module tb_ecc_tcdm_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   req,
  input logic                   gnt,
  input logic                   r_valid,
  input logic                   r_ready,
  input hci_size_pkg::data_t    r_data,
  input logic                   r_opc,
  input ecc_code_pkg::ecc_err_t r_err
);

  int n_fail = 0;

  // a pending response holds until it is taken
  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_opc) && $stable(r_err))
    else begin
      n_fail++;
      $error("response changed before r_ready");
    end

  // response one cycle after the handshake, gnt already dropped
  a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
    req && gnt |=> r_valid && !gnt)
    else begin
      n_fail++;
      $error("no response with gnt low one cycle after the handshake");
    end

  a_gnt_back: assert property (@(posedge clk) disable iff (rst)
    r_valid && r_ready |=> gnt && !r_valid)
    else begin
      n_fail++;
      $error("gnt not back after the response was taken");
    end

  a_err_code: assert property (@(posedge clk) disable iff (rst) r_err != 2'b11)
    else begin
      n_fail++;
      $error("r_err reports corrected and uncorrectable at once");
    end

endmodule

bind ecc_tcdm_top tb_ecc_tcdm_assert i_assert (
  .clk     ( clk     ),
  .rst     ( rst     ),
  .req     ( req     ),
  .gnt     ( gnt     ),
  .r_valid ( r_valid ),
  .r_ready ( r_ready ),
  .r_data  ( r_data  ),
  .r_opc   ( r_opc   ),
  .r_err   ( r_err   )
);

// ==== vlog.f ====
rtl/hci_size_pkg.sv
rtl/ecc_code_pkg.sv
rtl/hci_core_intf.sv
rtl/hsiao_ecc_enc.sv
rtl/hsiao_ecc_dec.sv
rtl/tcdm_ecc_bridge.sv
rtl/tcdm_bank_ctrl.sv
rtl/ecc_mem_array.sv
rtl/ecc_tcdm_top.sv
sim/tb_ecc_tcdm_assert.sv
sim/tb_ecc_tcdm.sv
